//--- hdl/exls_pkg.sv
// Shared types for the RV64 execute/load-store back end; data memory is word-addressed and byte addresses wrap at its size
package exls_pkg;

	localparam int xlen           = 64;
	localparam int reg_addr_bits  = 5;
	localparam int dmem_words     = 256;
	localparam int dmem_addr_bits = 8;   // log2(dmem_words)
	localparam int byte_off_bits  = 3;   // Byte lane within a 64-bit word

	typedef logic [xlen-1:0]          xlen_t;
	typedef logic [reg_addr_bits-1:0] reg_addr_t;

	// ALU function select
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		ls_none  = 2'd0,
		ls_load  = 2'd1,
		ls_store = 2'd2
	} ls_kind_e;

	typedef enum logic [1:0] {
		sz_byte   = 2'd0,
		sz_half   = 2'd1,
		sz_word   = 2'd2,
		sz_double = 2'd3
	} ls_size_e;

	typedef struct packed {
		ls_kind_e kind;
		ls_size_e size;
		logic     is_unsigned;   // Zero-extend on load
	} ls_ctl_t;

	// Op as issued by decode
	typedef struct packed {
		xlen_t     pc;
		alu_op_e   alu_op;
		xlen_t     src1;
		xlen_t     src2;
		xlen_t     store_data;
		ls_ctl_t   ls_ctl;
		logic      rd_ena;
		reg_addr_t rd_addr;
	} ex_op_t;

	// Op leaving execute, exu_res is the byte address for memory ops
	typedef struct packed {
		xlen_t     pc;
		xlen_t     exu_res;
		xlen_t     store_data;
		ls_ctl_t   ls_ctl;
		logic      rd_ena;
		reg_addr_t rd_addr;
	} ls_op_t;

	typedef struct packed {
		xlen_t     pc;
		logic      rd_ena;
		reg_addr_t rd_addr;
		xlen_t     rd_data;
	} wb_op_t;

endpackage

//--- hdl/pipe_reg.sv
// One-entry valid/ready stage register; flush empties it and blocks both sides for that cycle
`timescale 1ns/100ps

module pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     flush,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// Free slot, or the held item leaves this cycle
	assign in_ready  = !flush && (!valid_q || out_ready);
	assign out_valid = valid_q && !flush;
	assign out_data  = data_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;   // Drop whatever is held
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	// Stalled item stays put until it is taken or flushed
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> valid_q && $stable(out_data)
	);

	// No acceptance during flush, and empty right after it
	a_flush_empty: assert property (
		@(posedge clk) disable iff (!arst_n)
		flush |-> !in_ready ##1 !valid_q
	);

endmodule

//--- hdl/ex_stage.sv
// Combinational execute stage; shifts use src2[5:0] and memory ops compute their byte address with alu_add
`timescale 1ns/100ps

module ex_stage (
	input  logic                    issue_valid,
	input  exls_pkg::ex_op_t        ex_op,
	output exls_pkg::ls_op_t        ls_op,
	output logic                    fwd_valid,
	output exls_pkg::reg_addr_t     fwd_rd_addr,
	output exls_pkg::xlen_t         fwd_rd_data
);

	exls_pkg::xlen_t exu_res;
	logic [5:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;

	assign shamt       = ex_op.src2[5:0];
	assign lt_signed   = $signed(ex_op.src1) < $signed(ex_op.src2);
	assign lt_unsigned = ex_op.src1 < ex_op.src2;

	always_comb begin
		case (ex_op.alu_op)
			exls_pkg::alu_add:  exu_res = ex_op.src1 + ex_op.src2;
			exls_pkg::alu_sub:  exu_res = ex_op.src1 - ex_op.src2;
			exls_pkg::alu_and:  exu_res = ex_op.src1 & ex_op.src2;
			exls_pkg::alu_or:   exu_res = ex_op.src1 | ex_op.src2;
			exls_pkg::alu_xor:  exu_res = ex_op.src1 ^ ex_op.src2;
			exls_pkg::alu_sll:  exu_res = ex_op.src1 << shamt;
			exls_pkg::alu_srl:  exu_res = ex_op.src1 >> shamt;
			exls_pkg::alu_sra:  exu_res = $signed(ex_op.src1) >>> shamt;
			exls_pkg::alu_slt:  exu_res = {{(exls_pkg::xlen-1){1'b0}}, lt_signed};
			exls_pkg::alu_sltu: exu_res = {{(exls_pkg::xlen-1){1'b0}}, lt_unsigned};
			default:            exu_res = '0;   // Unused encodings
		endcase
	end

	always_comb begin
		ls_op.pc         = ex_op.pc;
		ls_op.exu_res    = exu_res;
		ls_op.store_data = ex_op.store_data;
		ls_op.ls_ctl     = ex_op.ls_ctl;
		ls_op.rd_ena     = ex_op.rd_ena;
		ls_op.rd_addr    = ex_op.rd_addr;
	end

	// Bypass for decode; load data only exists after the memory stage
	assign fwd_valid   = issue_valid && ex_op.rd_ena
		&& (ex_op.ls_ctl.kind != exls_pkg::ls_load);
	assign fwd_rd_addr = ex_op.rd_addr;
	assign fwd_rd_data = exu_res;

endmodule

//--- hdl/lsu_stage.sv
// Load/store stage with local data memory; accesses must be size-aligned and addresses wrap at the memory size
`timescale 1ns/100ps

module lsu_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             in_valid,
	input  logic             in_ready,
	input  exls_pkg::ls_op_t ls_op,
	output exls_pkg::wb_op_t wb_op
);

	exls_pkg::xlen_t mem [exls_pkg::dmem_words];

	logic [exls_pkg::dmem_addr_bits-1:0] word_addr;
	logic [exls_pkg::byte_off_bits-1:0]  byte_off;
	logic [7:0]                          byte_en;
	logic [exls_pkg::byte_off_bits-1:0]  align_mask;
	logic                                commit;
	logic                                store_commit;
	logic                                is_mem_op;
	exls_pkg::xlen_t                     store_wdata;
	exls_pkg::xlen_t                     rd_word;
	exls_pkg::xlen_t                     rd_shifted;
	exls_pkg::xlen_t                     load_data;

	assign word_addr = ls_op.exu_res[exls_pkg::byte_off_bits +: exls_pkg::dmem_addr_bits];
	assign byte_off  = ls_op.exu_res[exls_pkg::byte_off_bits-1:0];

	// The op moves into the writeback register this cycle
	assign commit       = in_valid && in_ready;
	assign store_commit = commit && (ls_op.ls_ctl.kind == exls_pkg::ls_store);
	assign is_mem_op    = ls_op.ls_ctl.kind != exls_pkg::ls_none;

	always_comb begin
		case (ls_op.ls_ctl.size)
			exls_pkg::sz_byte: begin
				byte_en    = 8'h01 << byte_off;
				align_mask = 3'b000;
			end
			exls_pkg::sz_half: begin
				byte_en    = 8'h03 << byte_off;
				align_mask = 3'b001;
			end
			exls_pkg::sz_word: begin
				byte_en    = 8'h0f << byte_off;
				align_mask = 3'b011;
			end
			default: begin
				byte_en    = 8'hff;
				align_mask = 3'b111;
			end
		endcase
	end

	assign store_wdata = ls_op.store_data << {byte_off, 3'b000};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < exls_pkg::dmem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (store_commit) begin
			for (int b = 0; b < 8; b++) begin
				if (byte_en[b]) begin
					mem[word_addr][8*b +: 8] <= store_wdata[8*b +: 8];
				end
			end
		end
	end

	// Load path, sees every store committed at an earlier edge
	assign rd_word    = mem[word_addr];
	assign rd_shifted = rd_word >> {byte_off, 3'b000};

	always_comb begin
		case (ls_op.ls_ctl.size)
			exls_pkg::sz_byte: begin
				load_data = ls_op.ls_ctl.is_unsigned
					? {{(exls_pkg::xlen-8){1'b0}}, rd_shifted[7:0]}
					: {{(exls_pkg::xlen-8){rd_shifted[7]}}, rd_shifted[7:0]};
			end
			exls_pkg::sz_half: begin
				load_data = ls_op.ls_ctl.is_unsigned
					? {{(exls_pkg::xlen-16){1'b0}}, rd_shifted[15:0]}
					: {{(exls_pkg::xlen-16){rd_shifted[15]}}, rd_shifted[15:0]};
			end
			exls_pkg::sz_word: begin
				load_data = ls_op.ls_ctl.is_unsigned
					? {{(exls_pkg::xlen-32){1'b0}}, rd_shifted[31:0]}
					: {{(exls_pkg::xlen-32){rd_shifted[31]}}, rd_shifted[31:0]};
			end
			default: load_data = rd_shifted;
		endcase
	end

	always_comb begin
		wb_op.pc      = ls_op.pc;
		wb_op.rd_ena  = ls_op.rd_ena;
		wb_op.rd_addr = ls_op.rd_addr;
		wb_op.rd_data = (ls_op.ls_ctl.kind == exls_pkg::ls_load) ? load_data : ls_op.exu_res;
	end

	// Address from execute must be aligned to the access size
	a_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid && is_mem_op |-> (byte_off & align_mask) == '0
	);

endmodule

//--- hdl/exls_backend.sv
// Back end top; flush drops only the op in the ex/ls register and at most two ops are in flight
`timescale 1ns/100ps

module exls_backend (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                flush,
	input  logic                issue_valid,
	output logic                issue_ready,
	input  exls_pkg::ex_op_t    issue,
	output logic                wb_valid,
	input  logic                wb_ready,
	output exls_pkg::wb_op_t    wb,
	output logic                fwd_valid,
	output exls_pkg::reg_addr_t fwd_rd_addr,
	output exls_pkg::xlen_t     fwd_rd_data
);

	exls_pkg::ls_op_t ex_ls_in;
	exls_pkg::ls_op_t ex_ls_out;
	logic             ex_ls_valid;
	logic             ls_wb_ready;
	exls_pkg::wb_op_t ls_wb_in;

	ex_stage ex_stage_i (
		.issue_valid (issue_valid),
		.ex_op       (issue),
		.ls_op       (ex_ls_in),
		.fwd_valid   (fwd_valid),
		.fwd_rd_addr (fwd_rd_addr),
		.fwd_rd_data (fwd_rd_data)
	);

	pipe_reg #(.payload_t(exls_pkg::ls_op_t)) ex_ls_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.in_valid  (issue_valid),
		.in_ready  (issue_ready),
		.in_data   (ex_ls_in),
		.out_valid (ex_ls_valid),
		.out_ready (ls_wb_ready),
		.out_data  (ex_ls_out)
	);

	lsu_stage lsu_stage_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (ex_ls_valid),
		.in_ready (ls_wb_ready),
		.ls_op    (ex_ls_out),
		.wb_op    (ls_wb_in)
	);

	// Committed ops, never flushed
	pipe_reg #(.payload_t(exls_pkg::wb_op_t)) ls_wb_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (1'b0),
		.in_valid  (ex_ls_valid),
		.in_ready  (ls_wb_ready),
		.in_data   (ls_wb_in),
		.out_valid (wb_valid),
		.out_ready (wb_ready),
		.out_data  (wb)
	);

endmodule

//--- testbench/exls_model.svh
// Reference ALU, load extension and store merge; accesses are size-aligned and stay inside one 64-bit word
`ifndef EXLS_MODEL_SVH
`define EXLS_MODEL_SVH

// Shift counts use the low six bits of b
function automatic exls_pkg::xlen_t alu_result(
	input exls_pkg::alu_op_e op,
	input exls_pkg::xlen_t   a,
	input exls_pkg::xlen_t   b
);
	exls_pkg::xlen_t msb;
	exls_pkg::xlen_t sign_fill;
	exls_pkg::xlen_t res;
	int              sh;
	msb       = 64'h8000_0000_0000_0000;
	sh        = int'(b[5:0]);
	sign_fill = a[63] ? ~(~64'd0 >> sh) : 64'd0;
	case (op)
		exls_pkg::alu_add:  res = a + b;
		exls_pkg::alu_sub:  res = a + ~b + 64'd1;
		exls_pkg::alu_and:  res = a & b;
		exls_pkg::alu_or:   res = a | b;
		exls_pkg::alu_xor:  res = a ^ b;
		exls_pkg::alu_sll:  res = a << sh;
		exls_pkg::alu_srl:  res = a >> sh;
		exls_pkg::alu_sra:  res = (a >> sh) | sign_fill;
		exls_pkg::alu_slt:  res = {63'd0, (a ^ msb) < (b ^ msb)};   // Offset binary compare
		exls_pkg::alu_sltu: res = {63'd0, a < b};
		default:            res = 64'd0;
	endcase
	return res;
endfunction

function automatic exls_pkg::xlen_t load_extend(
	input exls_pkg::xlen_t    word,
	input int                 off,
	input exls_pkg::ls_size_e size,
	input logic               uns
);
	exls_pkg::xlen_t val;
	int              nbytes;
	nbytes = 1 << size;
	val    = 64'd0;
	for (int i = 0; i < nbytes; i++) begin
		val[8*i +: 8] = word[8*(off+i) +: 8];
	end
	// Top loaded bit fills the upper bytes for signed loads
	if (!uns && val[8*nbytes-1]) begin
		for (int i = nbytes; i < 8; i++) begin
			val[8*i +: 8] = 8'hff;
		end
	end
	return val;
endfunction

function automatic exls_pkg::xlen_t store_merge(
	input exls_pkg::xlen_t    word,
	input int                 off,
	input exls_pkg::ls_size_e size,
	input exls_pkg::xlen_t    data
);
	exls_pkg::xlen_t merged;
	int              nbytes;
	nbytes = 1 << size;
	merged = word;
	for (int i = 0; i < nbytes; i++) begin
		merged[8*(off+i) +: 8] = data[8*i +: 8];   // Low store bytes land at the offset
	end
	return merged;
endfunction

`endif

//--- testbench/exls_backend_tb.sv
// Random-stimulus testbench for exls_backend; memory ops use 16 fixed words and size-aligned offsets
`timescale 1ns/100ps

module exls_backend_tb;

	localparam int num_ops        = 400;
	localparam int calm_ops       = 100;   // Issued with no flush and no back-pressure
	localparam int timeout_cycles = num_ops * 12;

	logic                clk = 1'b0;
	logic                arst_n;
	logic                flush;
	logic                issue_valid;
	logic                issue_ready;
	exls_pkg::ex_op_t    issue;
	logic                wb_valid;
	logic                wb_ready;
	exls_pkg::wb_op_t    wb;
	logic                fwd_valid;
	exls_pkg::reg_addr_t fwd_rd_addr;
	exls_pkg::xlen_t     fwd_rd_data;

	int seed        = 86897;
	int op_count    = 0;
	int cycle_count = 0;

	// Occupancy mirror of ex_ls_reg and ls_wb_reg
	logic             ex_full     = 1'b0;
	logic             wb_full     = 1'b0;
	logic             issue_taken = 1'b0;
	exls_pkg::ex_op_t ex_held;
	exls_pkg::xlen_t  model_mem [exls_pkg::dmem_words];
	exls_pkg::wb_op_t exp_q [$];

	logic             stalled    = 1'b0;
	exls_pkg::wb_op_t wb_held;
	logic [7:0]       last_widx  = 8'd0;
	logic             prev_store = 1'b0;

	`include "exls_model.svh"

	exls_backend exls_backend_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.flush       (flush),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue       (issue),
		.wb_valid    (wb_valid),
		.wb_ready    (wb_ready),
		.wb          (wb),
		.fwd_valid   (fwd_valid),
		.fwd_rd_addr (fwd_rd_addr),
		.fwd_rd_data (fwd_rd_data)
	);

	always #4 clk = ~clk;

	task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("[FAIL] time %0t %s expected %h got %h", $time, name, exp, got);
		$display("TEST FAIL");
		$fatal(1, "Wrong value on %s", name);
	endtask

	task automatic fail_text(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "%s", msg);
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [63:0] rand64();
		return {rand32(), rand32()};
	endfunction

	task automatic make_op(output exls_pkg::ex_op_t op);
		logic [31:0]     r;
		logic [31:0]     r2;
		logic            follow;
		logic [7:0]      widx;
		logic [2:0]      mask;
		exls_pkg::xlen_t addr;
		r      = rand32();
		r2     = rand32();
		follow = prev_store && r[12];   // Load right behind a store to the same word
		op     = '0;
		op.pc                 = 64'h8000_0000 + 64'(op_count) * 64'd4;
		op.rd_ena             = r[0] | r[1];
		op.rd_addr            = r[6:2];
		op.store_data         = rand64();
		op.ls_ctl.size        = exls_pkg::ls_size_e'(r[8:7]);
		op.ls_ctl.is_unsigned = r[9];
		if (follow || r[11:10] == 2'd2) begin
			op.ls_ctl.kind = exls_pkg::ls_load;
		end else if (r[11:10] == 2'd3) begin
			op.ls_ctl.kind = exls_pkg::ls_store;
		end else begin
			op.ls_ctl.kind = exls_pkg::ls_none;
		end
		if (op.ls_ctl.kind == exls_pkg::ls_none) begin
			op.alu_op = exls_pkg::alu_op_e'(4'(r[31:16] % 16'd10));
			op.src1   = rand64();
			case (r[14:13])
				2'd0:    op.src2 = rand64();
				2'd1:    op.src2 = rand64() | 64'h3f;   // Shift by 63
				2'd2:    op.src2 = op.src1 ^ 64'h8000_0000_0000_0000;
				default: op.src2 = op.src1;
			endcase
		end else begin
			widx      = follow ? last_widx : (r2[7:0] & 8'h87);
			mask      = {r[8] & r[7], r[8], r[8] | r[7]};   // Size minus one in bytes
			addr      = {53'd0, widx, r2[10:8] & ~mask};
			op.alu_op = exls_pkg::alu_add;
			op.src1   = rand64();
			op.src2   = addr - op.src1;
			if (op.ls_ctl.kind == exls_pkg::ls_store) begin
				op.rd_ena = 1'b0;
				last_widx = widx;
			end
		end
		prev_store = (op.ls_ctl.kind == exls_pkg::ls_store);
		op_count++;
	endtask

	// Applies the op to the model memory at its commit and returns the expected wb
	task automatic commit_model(input exls_pkg::ex_op_t op, output exls_pkg::wb_op_t exp);
		exls_pkg::xlen_t                     res;
		logic [exls_pkg::dmem_addr_bits-1:0] widx;
		int                                  off;
		res         = alu_result(op.alu_op, op.src1, op.src2);
		widx        = res[exls_pkg::byte_off_bits +: exls_pkg::dmem_addr_bits];
		off         = int'(res[exls_pkg::byte_off_bits-1:0]);
		exp.pc      = op.pc;
		exp.rd_ena  = op.rd_ena;
		exp.rd_addr = op.rd_addr;
		exp.rd_data = res;
		if (op.ls_ctl.kind == exls_pkg::ls_load) begin
			exp.rd_data = load_extend(model_mem[widx], off, op.ls_ctl.size, op.ls_ctl.is_unsigned);
		end else if (op.ls_ctl.kind == exls_pkg::ls_store) begin
			model_mem[widx] = store_merge(model_mem[widx], off, op.ls_ctl.size, op.store_data);
		end
	endtask

	// Works out the coming edge from inputs and mirror state, then steps the mirror
	always @(negedge clk) begin
		logic             ls_ready_m;
		logic             commit;
		logic             issue_ready_m;
		exls_pkg::wb_op_t exp;
		if (!arst_n) begin
			ex_full     = 1'b0;
			wb_full     = 1'b0;
			issue_taken = 1'b0;
		end else begin
			ls_ready_m    = !wb_full || wb_ready;
			commit        = ex_full && !flush && ls_ready_m;
			issue_ready_m = !flush && (!ex_full || commit);
			assert (issue_ready == issue_ready_m)
				else fail_value("issue_ready", 64'(issue_ready_m), 64'(issue_ready));
			assert (wb_valid == wb_full) else fail_value("wb_valid", 64'(wb_full), 64'(wb_valid));
			if (commit) begin
				commit_model(ex_held, exp);
				exp_q.push_back(exp);
			end
			if (ls_ready_m) begin
				wb_full = commit;
			end
			if (flush) begin
				ex_full = 1'b0;
			end else if (issue_ready_m) begin
				ex_full = issue_valid;
			end
			issue_taken = issue_valid && issue_ready_m;
			if (issue_taken) begin
				ex_held = issue;
			end
		end
	end

	always @(negedge clk) begin
		exls_pkg::wb_op_t exp;
		logic             fwd_exp;
		if (arst_n) begin
			if (stalled) begin
				assert (wb.pc == wb_held.pc) else fail_value("wb.pc", wb_held.pc, wb.pc);
				assert (wb.rd_data == wb_held.rd_data)
					else fail_value("wb.rd_data", wb_held.rd_data, wb.rd_data);
			end
			if (wb_valid && wb_ready) begin
				assert (exp_q.size() > 0) else fail_text("wb transfer with no op expected");
				exp = exp_q.pop_front();
				assert (wb.pc == exp.pc) else fail_value("wb.pc", exp.pc, wb.pc);
				assert (wb.rd_ena == exp.rd_ena)
					else fail_value("wb.rd_ena", 64'(exp.rd_ena), 64'(wb.rd_ena));
				assert (wb.rd_addr == exp.rd_addr)
					else fail_value("wb.rd_addr", 64'(exp.rd_addr), 64'(wb.rd_addr));
				assert (wb.rd_data == exp.rd_data)
					else fail_value("wb.rd_data", exp.rd_data, wb.rd_data);
			end
			stalled = wb_valid && !wb_ready;
			wb_held = wb;
			fwd_exp = issue_valid && issue.rd_ena && issue.ls_ctl.kind != exls_pkg::ls_load;
			assert (fwd_valid == fwd_exp)
				else fail_value("fwd_valid", 64'(fwd_exp), 64'(fwd_valid));
			if (fwd_exp) begin
				assert (fwd_rd_addr == issue.rd_addr)
					else fail_value("fwd_rd_addr", 64'(issue.rd_addr), 64'(fwd_rd_addr));
				assert (fwd_rd_data == alu_result(issue.alu_op, issue.src1, issue.src2))
					else fail_value("fwd_rd_data",
						alu_result(issue.alu_op, issue.src1, issue.src2), fwd_rd_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			fail_text("timeout, the pipeline did not drain in time");
		end
	end

	initial begin
		exls_pkg::ex_op_t op;
		logic             calm;
		arst_n      = 1'b0;
		flush       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		wb_ready    = 1'b1;
		for (int i = 0; i < exls_pkg::dmem_words; i++) begin
			model_mem[i] = 64'd0;
		end
		repeat (4) @(posedge clk);
		#1 arst_n = 1'b1;
		while (op_count < num_ops || issue_valid) begin
			@(posedge clk);
			#1;
			if (issue_taken) begin
				issue_valid = 1'b0;
			end
			calm = op_count < calm_ops;
			if (!issue_valid && op_count < num_ops && rand32() % 32'd8 != 0) begin
				make_op(op);
				issue       = op;
				issue_valid = 1'b1;
			end
			flush    = !calm && (rand32() % 32'd20 == 0);
			wb_ready = calm || (rand32() % 32'd10 >= 3);
		end
		flush    = 1'b0;
		wb_ready = 1'b1;
		while (ex_full || wb_full || exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(negedge clk);
		#1;
		if (wb_valid || !issue_ready) begin
			fail_text("pipeline still busy after the last op retired");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- exls_backend.f
+incdir+testbench
hdl/exls_pkg.sv
hdl/pipe_reg.sv
hdl/ex_stage.sv
hdl/lsu_stage.sv
hdl/exls_backend.sv
testbench/exls_backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the exls_backend testbench with Verilator, runs it and scans the log for failure

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=exls_backend_sim
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	-f exls_backend.f \
	--top-module exls_backend_tb \
	--Mdir "$build_dir" \
	-o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"

if grep -q "TEST FAIL" "$log_file"; then
	echo "Simulation reported a failure, see $log_file"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
